// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bit_packer
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
hw/bitpack_pkg.sv
hw/bitq_if.sv
hw/bit_fifo.sv
hw/sym_encoder.sv
hw/byte_emitter.sv
hw/bit_packer_top.sv
tb/tb_bit_packer.sv

// ==== hw/bit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_fifo #(
   parameter int WDATA_W = bitpack_pkg::CODE_MAX_W,
   parameter int RDATA_W = 8,
   parameter int REG_W   = 32
) (
   input wire logic clk_i,
   input wire logic arst_n_i,
   bitq_if.fifo_mp  q
);

   localparam int LVL_W = $clog2(REG_W) + 1;
   localparam logic [LVL_W-1:0] FULL_LVL = LVL_W'(REG_W);
   localparam logic [LVL_W-1:0] RD_STEP  = LVL_W'(RDATA_W);

   // valid bits sit at the top with zeros below rlevel
   logic [REG_W-1:0] data_q;
   logic [REG_W-1:0] data_d;
   logic [REG_W-1:0] shifted;
   logic [REG_W-1:0] wr_word;
   logic [REG_W-1:0] wr_mask;

   logic [LVL_W-1:0] wlevel_q;
   logic [LVL_W-1:0] wlevel_d;
   logic [LVL_W-1:0] rlevel_q;
   logic [LVL_W-1:0] rlevel_d;

   assign q.wlevel = wlevel_q;
   assign q.rlevel = rlevel_q;
   assign q.rdata  = data_q[REG_W-1 -: RDATA_W];

   // code moved to the register msb with unused low bits cleared
   assign wr_mask = ~({REG_W{1'b1}} >> q.wlen);

   always_comb begin
      wr_word = '0;
      wr_word[REG_W-1 -: WDATA_W] = q.wdata;
      wr_word = wr_word & wr_mask;
   end

   always_comb begin
      shifted  = data_q;
      rlevel_d = rlevel_q;
      wlevel_d = wlevel_q;

      // read first so the write lands behind the remaining bits
      if (q.read) begin
         shifted  = data_q << RDATA_W;
         rlevel_d = rlevel_q - RD_STEP;
         wlevel_d = wlevel_q + RD_STEP;
      end

      data_d = shifted;
      if (q.write) begin
         data_d   = shifted | (wr_word >> rlevel_d);
         rlevel_d = rlevel_d + LVL_W'(q.wlen);
         wlevel_d = wlevel_d - LVL_W'(q.wlen);
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         data_q   <= '0;
         wlevel_q <= FULL_LVL;
         rlevel_q <= '0;
      end else begin
         data_q   <= data_d;
         wlevel_q <= wlevel_d;
         rlevel_q <= rlevel_d;
      end
   end

   // a write fits the free space plus any same-cycle read
   a_no_overflow: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      q.write |-> int'(q.wlen) <= int'(wlevel_q) + (q.read ? RDATA_W : 0)
   );

   // emitter only reads whole bytes
   a_no_underflow: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      q.read |-> rlevel_q >= RD_STEP
   );

   // levels stay complementary across every update
   a_level_sum: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      int'(wlevel_q) + int'(rlevel_q) == REG_W
   );

endmodule

`default_nettype wire

// ==== hw/bit_packer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_packer_top #(
   parameter int WDATA_W = bitpack_pkg::CODE_MAX_W,
   parameter int RDATA_W = 8,
   parameter int REG_W   = 32
) (
   input  wire logic                   clk_i,
   input  wire logic                   arst_n_i,

   // symbol input
   input  wire logic                   in_req_i,
   input  wire bitpack_pkg::sym_word_u in_sym_i,
   output logic                        in_ack_o,

   // byte output
   output logic                        out_req_o,
   output logic [RDATA_W-1:0]          out_data_o,
   input  wire logic                   out_ack_i
);

   bitq_if #(
      .WDATA_W(WDATA_W),
      .RDATA_W(RDATA_W),
      .REG_W  (REG_W)
   ) bitq ();

   sym_encoder #(
      .WDATA_W(WDATA_W),
      .RDATA_W(RDATA_W),
      .REG_W  (REG_W)
   ) i_sym_encoder (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .in_req_i(in_req_i),
      .in_sym_i(in_sym_i),
      .in_ack_o(in_ack_o),
      .q       (bitq.wr_mp)
   );

   bit_fifo #(
      .WDATA_W(WDATA_W),
      .RDATA_W(RDATA_W),
      .REG_W  (REG_W)
   ) i_bit_fifo (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .q       (bitq.fifo_mp)
   );

   byte_emitter #(
      .WDATA_W(WDATA_W),
      .RDATA_W(RDATA_W),
      .REG_W  (REG_W)
   ) i_byte_emitter (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .q         (bitq.rd_mp),
      .out_req_o (out_req_o),
      .out_data_o(out_data_o),
      .out_ack_i (out_ack_i)
   );

endmodule

`default_nettype wire

// ==== hw/bitpack_pkg.sv ====
`default_nettype none

package bitpack_pkg;

   // symbol word and field widths
   localparam int SYM_W      = 24;
   localparam int RAW_LEN_W  = 5;
   localparam int RAW_BITS_W = 16;
   localparam int UE_VAL_W   = 8;

   // exp-golomb code of 255 is the longest code
   localparam int CODE_MAX_W = 17;

   typedef enum logic {
      SYM_RAW = 1'b0,
      SYM_UE  = 1'b1
   } sym_kind_e;

   // raw view keeps the bits right-aligned and uses only the low len bits
   typedef struct packed {
      sym_kind_e                         kind;
      logic [RAW_LEN_W-1:0]              len;
      logic [SYM_W-RAW_LEN_W-RAW_BITS_W-2:0] pad;
      logic [RAW_BITS_W-1:0]             bits;
   } sym_raw_t;

   // unsigned exp-golomb value
   typedef struct packed {
      sym_kind_e                  kind;
      logic [SYM_W-UE_VAL_W-2:0]  pad;
      logic [UE_VAL_W-1:0]        value;
   } sym_ue_t;

   // kind bit is the msb in both views
   typedef union packed {
      sym_raw_t raw;
      sym_ue_t  ue;
   } sym_word_u;

endpackage

`default_nettype wire

// ==== hw/bitq_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bitq_if #(
   parameter int WDATA_W = bitpack_pkg::CODE_MAX_W,
   parameter int RDATA_W = 8,
   parameter int REG_W   = 32
);

   // code is left-aligned in wdata
   logic                     write;
   logic [$clog2(WDATA_W):0] wlen;
   logic [WDATA_W-1:0]       wdata;
   logic [$clog2(REG_W):0]   wlevel;

   // every read takes RDATA_W bits
   logic                     read;
   logic [RDATA_W-1:0]       rdata;
   logic [$clog2(REG_W):0]   rlevel;

   // writer also sees read for same-cycle space
   modport wr_mp (output write, wlen, wdata, input wlevel, read);

   modport rd_mp (output read, input rdata, rlevel);

   modport fifo_mp (
      input  write, wlen, wdata, read,
      output wlevel, rdata, rlevel
   );

endinterface

`default_nettype wire

// ==== hw/byte_emitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_emitter #(
   parameter int WDATA_W = bitpack_pkg::CODE_MAX_W,
   parameter int RDATA_W = 8,
   parameter int REG_W   = 32
) (
   input  wire logic         clk_i,
   input  wire logic         arst_n_i,
   bitq_if.rd_mp             q,
   output logic              out_req_o,
   output logic [RDATA_W-1:0] out_data_o,
   input  wire logic         out_ack_i
);

   localparam int LVL_W = $clog2(REG_W) + 1;
   localparam logic [LVL_W-1:0] RD_STEP = LVL_W'(RDATA_W);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,
      ST_REL
   } state_e;

   state_e             state_q;
   logic               req_q;
   logic [RDATA_W-1:0] data_q;

   // a stalled writer gets room once bytes drain below RDATA_W
   if (WDATA_W > REG_W - RDATA_W + 1) begin : g_size_chk
      $error("byte_emitter: REG_W too small for WDATA_W and RDATA_W");
   end

   assign q.read     = (state_q == ST_IDLE) && (q.rlevel >= RD_STEP);
   assign out_req_o  = req_q;
   assign out_data_o = data_q;

   always_ff @(posedge clk_i) begin
      if (q.read) begin
         data_q <= q.rdata;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ST_IDLE;
         req_q   <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (q.read) begin
                  req_q   <= 1'b1;
                  state_q <= ST_REQ;
               end
            end
            ST_REQ: begin
               if (out_ack_i) begin
                  req_q   <= 1'b0;
                  state_q <= ST_REL;
               end
            end
            default: begin
               // wait for the sink to drop ack
               if (!out_ack_i) begin
                  state_q <= ST_IDLE;
               end
            end
         endcase
      end
   end

   a_data_stable: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      out_req_o |=> !out_req_o || $stable(out_data_o)
   );

endmodule

`default_nettype wire

// ==== hw/sym_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module sym_encoder #(
   parameter int WDATA_W = bitpack_pkg::CODE_MAX_W,
   parameter int RDATA_W = 8,
   parameter int REG_W   = 32
) (
   input  wire logic                   clk_i,
   input  wire logic                   arst_n_i,
   input  wire logic                   in_req_i,
   input  wire bitpack_pkg::sym_word_u in_sym_i,
   output logic                        in_ack_o,
   bitq_if.wr_mp                       q
);

   import bitpack_pkg::*;

   localparam int LEN_W = $clog2(WDATA_W) + 1;
   localparam int LVL_W = $clog2(REG_W) + 1;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SPACE,
      ST_ACK,
      ST_REL
   } state_e;

   state_e state_q;
   logic   ack_q;
   logic   space_ok;
   logic   take;

   // decoded symbol with the value right-aligned before shifting
   logic [UE_VAL_W:0]  ue_vp1;
   int unsigned        ue_n;
   logic [WDATA_W-1:0] enc_val;
   logic [WDATA_W-1:0] enc_code;
   logic [LEN_W-1:0]   enc_len;

   // held code
   logic [WDATA_W-1:0] code_q;
   logic [LEN_W-1:0]   len_q;
   logic [LVL_W-1:0]   room;

   assign ue_vp1 = {1'b0, in_sym_i.ue.value} + 1'b1;

   // bit width of value+1
   always_comb begin
      ue_n = 1;
      for (int i = 0; i <= UE_VAL_W; i++) begin
         if (ue_vp1[i]) begin
            ue_n = i + 1;
         end
      end
   end

   always_comb begin
      case (in_sym_i.raw.kind)
         SYM_UE: begin
            // n-1 leading zeros come from the shift below
            enc_val = WDATA_W'(ue_vp1);
            enc_len = LEN_W'(2 * ue_n - 1);
         end
         default: begin
            enc_val = WDATA_W'(in_sym_i.raw.bits);
            enc_len = LEN_W'(in_sym_i.raw.len);
         end
      endcase
   end

   // left-align so bits above len drop off the top
   assign enc_code = enc_val << (WDATA_W - int'(enc_len));

   assign take = (state_q == ST_IDLE) && in_req_i;

   assign room     = q.wlevel + (q.read ? LVL_W'(RDATA_W) : '0);
   assign space_ok = int'(room) >= int'(len_q);

   assign q.write  = (state_q == ST_SPACE) && space_ok;
   assign q.wlen   = len_q;
   assign q.wdata  = code_q;
   assign in_ack_o = ack_q;

   always_ff @(posedge clk_i) begin
      if (take) begin
         code_q <= enc_code;
         len_q  <= enc_len;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ST_IDLE;
         ack_q   <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (in_req_i) begin
                  state_q <= ST_SPACE;
               end
            end
            ST_SPACE: begin
               // stays here while the sink holds the buffer full
               if (space_ok) begin
                  ack_q   <= 1'b1;
                  state_q <= ST_ACK;
               end
            end
            ST_ACK: begin
               if (!in_req_i) begin
                  ack_q   <= 1'b0;
                  state_q <= ST_REL;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // source must send a length the buffer can take in one write
   a_len_range: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      take |-> (enc_len >= LEN_W'(1)) && (int'(enc_len) <= WDATA_W)
   );

endmodule

`default_nettype wire

// ==== tb/packer_trace.txt ====
# S <symbol word, hex> is sent on the input port in file order
# B <byte, hex> is the next byte expected on the output port
# raw fields of 1, 3, 8, 16, 3 and 1 bits
S 040001
S 0C0002
S 2000A5
S 401234
S 0C0007
S 040000
B AA
B 51
B 23
B 4E
# exp-golomb 0, 1, 2, 7, 255 and one raw bit
S 800000
S 800001
S 800002
S 800007
S 8000FF
S 040001
B A6
B 20
B 02
B 01
# long codes that fill the buffer
S 40BEEF
S 8000FF
S 40CAFE
S 8000FF
S 18002A
B BE
B EF
B 00
B 80
B 65
B 7F
B 00
B 40
B 2A

// ==== tb/tb_bit_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bit_packer;

   import bitpack_pkg::*;

   localparam int WDATA_W  = 17;
   localparam int RDATA_W  = 8;
   localparam int REG_W    = 32;
   localparam int TIMEOUT  = 200;
   localparam int IDLE_CYC = 20;

   logic                   clk;
   logic                   arst_n;
   logic                   in_req;
   sym_word_u              in_sym;
   logic                   in_ack;
   logic                   out_req;
   logic [RDATA_W-1:0]     out_data;
   logic                   out_ack;

   // trace contents in file order
   logic [SYM_W-1:0] sym_q[$];
   logic [7:0]       byte_q[$];

   // values seen at the previous falling edge
   logic               prev_in_req;
   logic               prev_in_ack;
   logic               prev_out_req;
   logic               prev_out_ack;
   logic [RDATA_W-1:0] prev_out_data;

   bit_packer_top #(
      .WDATA_W(WDATA_W),
      .RDATA_W(RDATA_W),
      .REG_W  (REG_W)
   ) i_dut (
      .clk_i     (clk),
      .arst_n_i  (arst_n),
      .in_req_i  (in_req),
      .in_sym_i  (in_sym),
      .in_ack_o  (in_ack),
      .out_req_o (out_req),
      .out_data_o(out_data),
      .out_ack_i (out_ack)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
      end
   endtask

   // sel 0 watches in_ack_o and sel 1 watches out_req_o
   task automatic wait_level(input int sel, input logic level, input string what);
      int n;
      n = 0;
      @(negedge clk);
      while (((sel == 0) ? in_ack : out_req) !== level) begin
         if (n == TIMEOUT) begin
            abort_run($sformatf("timeout after %0d cycles waiting for %s", TIMEOUT, what));
         end
         n++;
         @(negedge clk);
      end
   endtask

   task automatic load_trace();
      int          fd;
      int          cnt;
      string       line;
      logic [7:0]  tag;
      logic [31:0] val;
      fd = $fopen("tb/packer_trace.txt", "r");
      if (fd == 0) begin
         abort_run("could not open the trace file tb/packer_trace.txt");
      end
      while (!$feof(fd)) begin
         cnt = $fgets(line, fd);
         if (cnt > 0) begin
            cnt = $sscanf(line, "%c %h", tag, val);
            if (cnt == 2 && tag == "S") begin
               sym_q.push_back(val[SYM_W-1:0]);
            end else if (cnt == 2 && tag == "B") begin
               byte_q.push_back(val[7:0]);
            end
         end
      end
      $fclose(fd);
      if (sym_q.size() == 0 || byte_q.size() == 0) begin
         abort_run("the trace file holds no symbols or no expected bytes");
      end
   endtask

   task automatic send_symbols();
      foreach (sym_q[i]) begin
         repeat ($urandom_range(2, 0)) @(posedge clk);
         @(posedge clk);
         in_sym <= sym_q[i];
         in_req <= 1'b1;
         wait_level(0, 1'b1, "in_ack_o to rise");
         @(posedge clk);
         in_req <= 1'b0;
         wait_level(0, 1'b0, "in_ack_o to fall");
      end
   endtask

   // slow sink that acks 0 to 5 cycles late
   task automatic collect_bytes();
      foreach (byte_q[i]) begin
         wait_level(1, 1'b1, "out_req_o to rise");
         check_value($sformatf("out_data_o byte %0d", i), 32'(out_data), 32'(byte_q[i]));
         repeat ($urandom_range(5, 0)) @(posedge clk);
         @(posedge clk);
         out_ack <= 1'b1;
         wait_level(1, 1'b0, "out_req_o to fall");
         @(posedge clk);
         out_ack <= 1'b0;
      end
   endtask

   task automatic expect_no_byte(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         check_value("out_req_o", 32'(out_req), 32'h0);
      end
   endtask

   // four-phase ordering on both ports
   always @(negedge clk) begin
      if (arst_n) begin
         if (prev_in_ack && !in_ack) begin
            check_value("in_req_i", 32'(prev_in_req), 32'h0);
         end
         if (prev_out_req && !out_req) begin
            check_value("out_ack_i", 32'(prev_out_ack), 32'h1);
         end
         if (prev_out_req && out_req) begin
            check_value("out_data_o", 32'(out_data), 32'(prev_out_data));
         end
      end
      prev_in_req   = in_req;
      prev_in_ack   = in_ack;
      prev_out_req  = out_req;
      prev_out_ack  = out_ack;
      prev_out_data = out_data;
   end

   initial begin
      void'($urandom(55884));
      arst_n        = 1'b0;
      in_req        = 1'b0;
      in_sym        = '0;
      out_ack       = 1'b0;
      prev_in_req   = 1'b0;
      prev_in_ack   = 1'b0;
      prev_out_req  = 1'b0;
      prev_out_ack  = 1'b0;
      prev_out_data = '0;
      load_trace();

      repeat (16) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      check_value("in_ack_o", 32'(in_ack), 32'h0);
      check_value("out_req_o", 32'(out_req), 32'h0);
      expect_no_byte(IDLE_CYC);

      fork
         send_symbols();
         collect_bytes();
      join

      // stream ends on a byte boundary so nothing may follow
      expect_no_byte(IDLE_CYC);
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire
